// File: include/cache_tb_vectors.svh
// Vector table for the cache testbench, included inside cache_tb.
// Columns: op, size, zero_ext, addr, wdata, expected hit, expected rdata,
// rdata checked, extra cycles that req stays high after ack.

`ifndef CACHE_TB_VECTORS_SVH
`define CACHE_TB_VECTORS_SVH

function automatic void build_table();
    add_vec(LD, WORD, 0, 32'h0000_2020, 32'h0000_0000, 0, 32'h0000_0000, 1, 0);  // cold miss
    add_vec(FL, WORD, 0, 32'h0000_1010, 32'h807F_F080, 0, 32'h0000_0000, 1, 0);
    add_vec(LD, WORD, 0, 32'h0000_1010, 32'h0000_0000, 1, 32'h807F_F080, 1, 0);
    add_vec(LD, WORD, 0, 32'h0000_1014, 32'h0000_0000, 1, 32'h0000_0000, 0, 0);  // word never filled
    // byte and half lanes, signed then unsigned
    add_vec(LD, BYTE, 0, 32'h0000_1010, 32'h0000_0000, 1, 32'hFFFF_FF80, 1, 0);
    add_vec(LD, BYTE, 1, 32'h0000_1010, 32'h0000_0000, 1, 32'h0000_0080, 1, 0);
    add_vec(LD, BYTE, 0, 32'h0000_1011, 32'h0000_0000, 1, 32'hFFFF_FFF0, 1, 0);
    add_vec(LD, BYTE, 1, 32'h0000_1011, 32'h0000_0000, 1, 32'h0000_00F0, 1, 0);
    add_vec(LD, BYTE, 0, 32'h0000_1012, 32'h0000_0000, 1, 32'h0000_007F, 1, 0);
    add_vec(LD, BYTE, 1, 32'h0000_1013, 32'h0000_0000, 1, 32'h0000_0080, 1, 0);
    add_vec(LD, HALF, 0, 32'h0000_1010, 32'h0000_0000, 1, 32'hFFFF_F080, 1, 0);
    add_vec(LD, HALF, 1, 32'h0000_1010, 32'h0000_0000, 1, 32'h0000_F080, 1, 0);
    add_vec(LD, HALF, 0, 32'h0000_1012, 32'h0000_0000, 1, 32'hFFFF_807F, 1, 0);
    add_vec(LD, HALF, 1, 32'h0000_1012, 32'h0000_0000, 1, 32'h0000_807F, 1, 0);
    add_vec(LD, HALF, 0, 32'h0000_1013, 32'h0000_0000, 1, 32'hFFFF_807F, 1, 0);  // bit 0 ignored
    add_vec(LD, WORD, 0, 32'h0000_1013, 32'h0000_0000, 1, 32'h807F_F080, 1, 0);
    // store merge into a second word of the same line
    add_vec(FL, WORD, 0, 32'h0000_1018, 32'h1122_3344, 1, 32'h0000_0000, 1, 0);
    add_vec(ST, BYTE, 0, 32'h0000_1019, 32'hFFFF_FFAB, 1, 32'h0000_0000, 1, 0);
    add_vec(ST, HALF, 0, 32'h0000_101A, 32'h1234_CDEF, 1, 32'h0000_0000, 1, 0);
    add_vec(LD, WORD, 0, 32'h0000_1018, 32'h0000_0000, 1, 32'hCDEF_AB44, 1, 0);
    add_vec(ST, WORD, 0, 32'h0000_3010, 32'h5555_5555, 0, 32'h0000_0000, 1, 0);  // store miss
    add_vec(LD, WORD, 0, 32'h0000_3010, 32'h0000_0000, 0, 32'h0000_0000, 1, 0);
    // set 2: tags 0a..0d fill ways 0..3, touch 0a, then 0e evicts 0b
    add_vec(FL, WORD, 0, 32'h0000_0A20, 32'hA0A0_0001, 0, 32'h0000_0000, 1, 0);
    add_vec(FL, WORD, 0, 32'h0000_0B20, 32'hB0B0_0002, 0, 32'h0000_0000, 1, 0);
    add_vec(FL, WORD, 0, 32'h0000_0C20, 32'hC0C0_0003, 0, 32'h0000_0000, 1, 0);
    add_vec(FL, WORD, 0, 32'h0000_0D20, 32'hD0D0_0004, 0, 32'h0000_0000, 1, 0);
    add_vec(LD, WORD, 0, 32'h0000_0A20, 32'h0000_0000, 1, 32'hA0A0_0001, 1, 0);
    add_vec(FL, WORD, 0, 32'h0000_0E20, 32'hE0E0_0005, 0, 32'h0000_0000, 1, 0);
    add_vec(LD, WORD, 0, 32'h0000_0B20, 32'h0000_0000, 0, 32'h0000_0000, 1, 0);
    add_vec(LD, WORD, 0, 32'h0000_0A20, 32'h0000_0000, 1, 32'hA0A0_0001, 1, 0);
    add_vec(LD, WORD, 0, 32'h0000_0C20, 32'h0000_0000, 1, 32'hC0C0_0003, 1, 0);
    add_vec(LD, WORD, 0, 32'h0000_0D20, 32'h0000_0000, 1, 32'hD0D0_0004, 1, 0);
    add_vec(LD, WORD, 0, 32'h0000_0E20, 32'h0000_0000, 1, 32'hE0E0_0005, 1, 0);
    // back-pressure, then a normal request
    add_vec(LD, WORD, 0, 32'h0000_1010, 32'h0000_0000, 1, 32'h807F_F080, 1, 3);
    add_vec(LD, BYTE, 1, 32'h0000_1011, 32'h0000_0000, 1, 32'h0000_00F0, 1, 0);
endfunction

`endif

// File: dv/cache_tb.sv
// Testbench for the four-way data cache. Walks the vector table through
// the req/ack handshake and checks hit and load data of every response.

`default_nettype none

module cache_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ACK_WAIT = 8;  // cycles allowed for each ack edge

    localparam cache_op_pkg::cache_op_e    LD   = cache_op_pkg::OP_LOAD;
    localparam cache_op_pkg::cache_op_e    ST   = cache_op_pkg::OP_STORE;
    localparam cache_op_pkg::cache_op_e    FL   = cache_op_pkg::OP_FILL;
    localparam cache_op_pkg::access_size_e BYTE = cache_op_pkg::SIZE_BYTE;
    localparam cache_op_pkg::access_size_e HALF = cache_op_pkg::SIZE_HALF;
    localparam cache_op_pkg::access_size_e WORD = cache_op_pkg::SIZE_WORD;

    typedef struct {
        cache_op_pkg::cache_req_t   req;
        logic                       hit;
        cache_geom_pkg::word_t      rdata;
        logic                       chk_data;  // unfilled words hold no known data
        int                         hold;
    } vector_t;

    logic                       clk;
    logic                       reset;
    logic                       req;
    cache_op_pkg::cache_req_t   request;
    logic                       ack;
    cache_op_pkg::cache_resp_t  response;

    vector_t    vectors[$];
    int         mismatches;
    int         failures;
    int         cycles;
    int         max_cycles;

    function automatic void add_vec(
        input cache_op_pkg::cache_op_e      op,
        input cache_op_pkg::access_size_e   size,
        input logic                         zext,
        input logic [31:0]                  addr,
        input cache_geom_pkg::word_t        wdata,
        input logic                         hit,
        input cache_geom_pkg::word_t        rdata,
        input logic                         chk,
        input int                           hold
    );
        vector_t v;
        v.req.op       = op;
        v.req.size     = size;
        v.req.zero_ext = zext;
        v.req.addr     = addr;
        v.req.wdata    = wdata;
        v.hit          = hit;
        v.rdata        = rdata;
        v.chk_data     = chk;
        v.hold         = hold;
        vectors.push_back(v);
    endfunction

    `include "cache_tb_vectors.svh"

    cache_top #(
        .INDEX_BITS (cache_geom_pkg::DEF_INDEX_BITS)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .request  (request),
        .ack      (ack),
        .response (response)
    );

    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("run stopped after %0d cycles, handshakes did not complete", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_response(input int idx, input vector_t v);
        if (response.hit !== v.hit) begin
            mismatches++;
            $display("Mismatch entry %0d response.hit: got %h expected %h",
                     idx, response.hit, v.hit);
        end
        if (v.chk_data && response.rdata !== v.rdata) begin
            mismatches++;
            $display("Mismatch entry %0d response.rdata: got %h expected %h",
                     idx, response.rdata, v.rdata);
        end
    endtask

    task automatic run_vector(input int idx);
        vector_t    v;
        int         waited;
        v = vectors[idx];
        @(posedge clk);
        req     <= 1'b1;
        request <= v.req;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack && waited < ACK_WAIT);
        if (!ack) begin
            failures++;
            $display("entry %0d: ack did not rise within %0d cycles", idx, ACK_WAIT);
        end else begin
            check_response(idx, v);
            for (int h = 0; h < v.hold; h++) begin
                @(negedge clk);
                if (!ack) begin
                    failures++;
                    $display("entry %0d: ack dropped while req was still high", idx);
                end
                check_response(idx, v);
            end
        end
        @(posedge clk);
        req <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (ack && waited < ACK_WAIT);
        if (ack) begin
            failures++;
            $display("entry %0d: ack stayed high after req dropped", idx);
        end
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        req        = 1'b0;
        request    = '0;
        mismatches = 0;
        failures   = 0;
        cycles     = 0;
        build_table();
        max_cycles = 10 * vectors.size() + 20;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < vectors.size(); i++) begin
            run_vector(i);
        end
        $display("entries: %0d  mismatches: %0d  other errors: %0d",
                 vectors.size(), mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
// packages first, then RTL leaves up to the top, then the testbench
+incdir+include
rtl/cache_geom_pkg.sv
rtl/cache_op_pkg.sv
rtl/lru_ages.sv
rtl/byte_lanes.sv
rtl/cache_sets.sv
rtl/cache_req_port.sv
rtl/cache_top.sv
dv/cache_tb.sv

// File: rtl/byte_lanes.sv
// Byte-lane unit: extracts and extends load data from the addressed word,
// and merges store data into it. Purely combinational.

`default_nettype none

module byte_lanes (
    input  wire cache_op_pkg::cache_req_t   cur_req,
    input  wire cache_geom_pkg::word_t      stored_word,
    output cache_geom_pkg::word_t           load_value,
    output cache_geom_pkg::word_t           merged_word
);

    logic [1:0]  offset;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign offset   = cur_req.addr[1:0];
    assign sel_byte = stored_word[{offset, 3'b000} +: 8];
    assign sel_half = offset[1] ? stored_word[31:16] : stored_word[15:0];

    always_comb begin
        case (cur_req.size)
            cache_op_pkg::SIZE_BYTE: begin
                load_value = cur_req.zero_ext ? {24'b0, sel_byte} : {{24{sel_byte[7]}}, sel_byte};
            end
            cache_op_pkg::SIZE_HALF: begin
                load_value = cur_req.zero_ext ? {16'b0, sel_half} : {{16{sel_half[15]}}, sel_half};
            end
            default: load_value = stored_word;  // word ignores offset
        endcase
    end

    // only the addressed lanes take new data
    always_comb begin
        merged_word = stored_word;
        case (cur_req.size)
            cache_op_pkg::SIZE_BYTE: begin
                merged_word[{offset, 3'b000} +: 8] = cur_req.wdata[7:0];
            end
            cache_op_pkg::SIZE_HALF: begin
                merged_word[{offset[1], 4'b0000} +: 16] = cur_req.wdata[15:0];
            end
            default: merged_word = cur_req.wdata;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/cache_geom_pkg.sv
// Address geometry and storage types of the set-associative data cache.
// Referenced by scoped name from the RTL and the testbench.

`default_nettype none

package cache_geom_pkg;

    // address layout, msb to lsb: tag | set index | word select | byte offset
    localparam int ADDR_BITS      = 32;
    localparam int WORD_BITS      = 32;
    localparam int OFFSET_BITS    = 2;  // byte within word
    localparam int WORD_SEL_BITS  = 2;  // word within line

    localparam int WAYS           = 4;
    localparam int AGE_BITS       = 2;

    // 16 sets unless the top level overrides it
    localparam int DEF_INDEX_BITS = 4;

    // one data word
    typedef logic [WORD_BITS-1:0] word_t;

    // lru age, 0 is most recent
    typedef logic [AGE_BITS-1:0] age_t;

    // way number within a set
    typedef logic [1:0] way_t;

endpackage

`default_nettype wire

// File: rtl/cache_op_pkg.sv
// Operation codes, access sizes and the request and response records
// that travel over the cache's handshake port.

`default_nettype none

package cache_op_pkg;

    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_FILL  = 2'd2
    } cache_op_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // 69 bits
    typedef struct packed {
        cache_op_e                              op;
        access_size_e                           size;
        logic                                   zero_ext;  // lbu / lhu style load
        logic [cache_geom_pkg::ADDR_BITS-1:0]   addr;
        cache_geom_pkg::word_t                  wdata;
    } cache_req_t;

    // 33 bits
    typedef struct packed {
        logic                   hit;
        cache_geom_pkg::word_t  rdata;
    } cache_resp_t;

endpackage

`default_nettype wire

// File: rtl/cache_req_port.sv
// Four-phase req/ack port. Latches one request, strobes access for a
// single cycle, registers the response and holds ack until req drops.

`default_nettype none

module cache_req_port (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       req,
    input  wire cache_op_pkg::cache_req_t   request,
    output logic                            ack,
    output cache_op_pkg::cache_resp_t       response,
    output logic                            access,
    output cache_op_pkg::cache_req_t        cur_req,
    input  wire logic                       hit,
    input  wire cache_geom_pkg::word_t      load_value
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        ACK
    } state_e;

    state_e state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            response <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= ACCESS;
                    end
                end
                ACCESS: begin
                    state         <= ACK;
                    response.hit  <= hit;
                    // only a hitting load returns data
                    if (cur_req.op == cache_op_pkg::OP_LOAD && hit) begin
                        response.rdata <= load_value;
                    end else begin
                        response.rdata <= '0;
                    end
                end
                ACK: begin
                    if (!req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request capture, one per handshake
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            cur_req <= request;
        end
    end

    assign access = (state == ACCESS);
    assign ack    = (state == ACK);  // response already stable here

    // requester must hold the request until it sees ack
    a_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        (req && $past(req) && !ack) |-> $stable(request)
    );

endmodule

`default_nettype wire

// File: rtl/cache_sets.sv
// Set store of the cache: tag, valid and data arrays with hit detection.
// Picks the hit way or the lru victim and performs store and fill writes.

`default_nettype none

module cache_sets #(
    parameter int INDEX_BITS = cache_geom_pkg::DEF_INDEX_BITS
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       access,
    input  wire cache_op_pkg::cache_req_t   cur_req,
    input  wire cache_geom_pkg::word_t      merged_word,
    output logic                            hit,
    output cache_geom_pkg::word_t           stored_word
);

    localparam int LOW_BITS   = cache_geom_pkg::OFFSET_BITS + cache_geom_pkg::WORD_SEL_BITS;
    localparam int TAG_BITS   = cache_geom_pkg::ADDR_BITS - INDEX_BITS - LOW_BITS;
    localparam int SETS       = 1 << INDEX_BITS;
    localparam int LINE_WORDS = 1 << cache_geom_pkg::WORD_SEL_BITS;
    localparam int WAYS       = cache_geom_pkg::WAYS;

    logic [TAG_BITS-1:0]                        tag_mem  [SETS][WAYS];
    cache_geom_pkg::word_t                      data_mem [SETS][WAYS][LINE_WORDS];
    logic [WAYS-1:0]                            valid_q  [SETS];

    logic [TAG_BITS-1:0]                        addr_tag;
    logic [INDEX_BITS-1:0]                      set_idx;
    logic [cache_geom_pkg::WORD_SEL_BITS-1:0]   word_sel;
    logic [WAYS-1:0]                            way_hit;
    cache_geom_pkg::way_t                       hit_way;
    cache_geom_pkg::way_t                       victim;
    cache_geom_pkg::way_t                       target_way;
    logic                                       is_load;
    logic                                       is_store;
    logic                                       is_fill;
    logic                                       touch;

    assign addr_tag = cur_req.addr[cache_geom_pkg::ADDR_BITS-1 -: TAG_BITS];
    assign set_idx  = cur_req.addr[LOW_BITS +: INDEX_BITS];
    assign word_sel = cur_req.addr[cache_geom_pkg::OFFSET_BITS +: cache_geom_pkg::WORD_SEL_BITS];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid_q[set_idx][w] && (tag_mem[set_idx][w] == addr_tag);
            if (way_hit[w]) begin
                hit_way = cache_geom_pkg::way_t'(w);
            end
        end
    end

    assign hit         = |way_hit;
    assign stored_word = data_mem[set_idx][hit_way][word_sel];
    assign target_way  = hit ? hit_way : victim;  // refill in place if tag present

    assign is_load  = (cur_req.op == cache_op_pkg::OP_LOAD);
    assign is_store = (cur_req.op == cache_op_pkg::OP_STORE);
    assign is_fill  = (cur_req.op == cache_op_pkg::OP_FILL);
    assign touch    = access && (is_fill || ((is_load || is_store) && hit));

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (access && is_fill) begin
            valid_q[set_idx][target_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (access && is_fill) begin
            data_mem[set_idx][target_way][word_sel] <= cur_req.wdata;
            tag_mem[set_idx][target_way]            <= addr_tag;
        end else if (access && is_store && hit) begin
            data_mem[set_idx][hit_way][word_sel] <= merged_word;
        end
    end

    lru_ages #(
        .INDEX_BITS (INDEX_BITS)
    ) u_lru (
        .clk        (clk),
        .reset      (reset),
        .set_index  (set_idx),
        .touch      (touch),
        .touch_way  (target_way),
        .victim     (victim)
    );

    // fills reuse the hit way, so a tag never lands in two ways
    a_single_hit: assert property (
        @(posedge clk) disable iff (reset)
        access |-> $onehot0(way_hit)
    );

endmodule

`default_nettype wire

// File: rtl/cache_top.sv
// Top level of the four-way data cache. Connects the handshake port,
// the set store and the byte lanes; INDEX_BITS sets the number of sets.

`default_nettype none

module cache_top #(
    parameter int INDEX_BITS = cache_geom_pkg::DEF_INDEX_BITS
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       req,
    input  wire cache_op_pkg::cache_req_t   request,
    output logic                            ack,
    output cache_op_pkg::cache_resp_t       response
);

    logic                       access;
    cache_op_pkg::cache_req_t   cur_req;
    logic                       hit;
    cache_geom_pkg::word_t      stored_word;
    cache_geom_pkg::word_t      load_value;
    cache_geom_pkg::word_t      merged_word;

    cache_req_port u_port (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .request    (request),
        .ack        (ack),
        .response   (response),
        .access     (access),
        .cur_req    (cur_req),
        .hit        (hit),
        .load_value (load_value)
    );

    cache_sets #(.INDEX_BITS(INDEX_BITS)) u_sets (
        .clk         (clk),
        .reset       (reset),
        .access      (access),
        .cur_req     (cur_req),
        .merged_word (merged_word),
        .hit         (hit),
        .stored_word (stored_word)
    );

    byte_lanes u_lanes (
        .cur_req     (cur_req),
        .stored_word (stored_word),
        .load_value  (load_value),
        .merged_word (merged_word)
    );

endmodule

`default_nettype wire

// File: rtl/lru_ages.sv
// True LRU ordering for each set, kept as a 2-bit age per way.
// A touch makes a way age 0; the way with the oldest age is the victim.

`default_nettype none

module lru_ages #(
    parameter int INDEX_BITS = cache_geom_pkg::DEF_INDEX_BITS
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [INDEX_BITS-1:0]  set_index,
    input  wire logic                   touch,
    input  wire cache_geom_pkg::way_t   touch_way,
    output cache_geom_pkg::way_t        victim
);

    localparam int SETS = 1 << INDEX_BITS;
    localparam int WAYS = cache_geom_pkg::WAYS;

    cache_geom_pkg::age_t [WAYS-1:0] ages [SETS];
    cache_geom_pkg::age_t            old_age;

    function automatic logic is_perm(input cache_geom_pkg::age_t [WAYS-1:0] a);
        logic [WAYS-1:0] seen;
        seen = '0;
        for (int w = 0; w < WAYS; w++) begin
            seen[a[w]] = 1'b1;
        end
        return &seen;
    endfunction

    assign old_age = ages[set_index][touch_way];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    ages[s][w] <= cache_geom_pkg::age_t'(WAYS - 1 - w);  // way0 oldest
                end
            end
        end else if (touch) begin
            for (int w = 0; w < WAYS; w++) begin
                if (cache_geom_pkg::way_t'(w) == touch_way) begin
                    ages[set_index][w] <= '0;
                end else if (ages[set_index][w] < old_age) begin
                    ages[set_index][w] <= ages[set_index][w] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        victim = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (ages[set_index][w] == cache_geom_pkg::age_t'(WAYS - 1)) begin
                victim = cache_geom_pkg::way_t'(w);
            end
        end
    end

    a_ages_perm: assert property (
        @(posedge clk) disable iff (reset)
        touch |=> is_perm(ages[$past(set_index)])
    );

endmodule

`default_nettype wire
